// ==== src.f ====
src/stq_pkg.sv
src/stq_entry.sv
src/stq_fwd_check.sv
src/stq_store_drain.sv
src/stq_top.sv
sim/tb_stq.sv

// ==== Bender.yml ====
package:
  name: stq

sources:
  - src/stq_pkg.sv
  - src/stq_entry.sv
  - src/stq_fwd_check.sv
  - src/stq_store_drain.sv
  - src/stq_top.sv
  - target: simulation
    files:
      - sim/tb_stq.sv

// ==== sim/tb_stq.sv ====
module tb_stq
  import stq_pkg::*;
();

  localparam int TIMEOUT = 200;   // Cycles per wait

  logic                 clk;
  logic                 reset_n;
  logic                 disp_valid;
  addr_upd_t            addr_upd;
  data_upd_t            data_upd;
  logic                 commit;
  fwd_req_t             fwd_req;
  logic                 wr_conflict;
  logic [STQ_IDX_W-1:0] disp_index;
  logic                 full;
  fwd_resp_t            fwd_resp;
  l1d_wr_t              l1d_wr;

  string                test_name;
  int                   err_count;
  int                   test_count;
  int                   fail_count;
  logic                 chk_idle;
  logic [31:0]          lfsr;

  // Reference queue, one slot per ring position
  logic [STQ_SIZE-1:0]  m_live;
  logic [STQ_SIZE-1:0]  m_addr_v;
  logic [STQ_SIZE-1:0]  m_data_v;
  logic [PADDR_W-1:0]   m_paddr [STQ_SIZE];
  mem_size_e            m_size [STQ_SIZE];
  logic [XLEN-1:0]      m_data [STQ_SIZE];
  logic [STQ_IDX_W-1:0] m_tail;
  logic [STQ_IDX_W-1:0] m_head;
  int                   m_count;
  int                   m_pending;   // Committed, not yet written
  int                   acc_count;

  logic [PADDR_W-1:0]    exp_wr_paddr;
  logic [L1D_BYTE_W-1:0] exp_wr_be;
  logic [L1D_DATA_W-1:0] exp_wr_data;
  logic                  exp_fwd_valid;
  logic                  exp_hazard;
  logic [7:0]            exp_fwd_be;
  logic [XLEN-1:0]       exp_fwd_data;

  stq_top UUT (
    .i_clk             (clk),
    .i_reset_n         (reset_n),
    .i_disp_valid      (disp_valid),
    .i_addr_upd        (addr_upd),
    .i_data_upd        (data_upd),
    .i_commit          (commit),
    .i_fwd_req         (fwd_req),
    .i_l1d_wr_conflict (wr_conflict),
    .o_disp_index      (disp_index),
    .o_full            (full),
    .o_fwd_resp        (fwd_resp),
    .o_l1d_wr          (l1d_wr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ========================================
  // Helpers
  // ========================================
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // x^32 + x^22 + x^2 + x + 1
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[62:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [PADDR_W-1:0] rand_paddr(mem_size_e size);
    logic [PADDR_W-1:0] a;
    a = PADDR_W'(rand_bits(PADDR_W));
    a[3:0] = a[3:0] & ~4'((1 << size) - 1);   // Natural alignment
    return a;
  endfunction

  // Bytes touched by an access, from the low byte at ofs
  function automatic logic [15:0] byte_mask(mem_size_e size, logic [3:0] ofs);
    logic [15:0] low;
    low = (16'd1 << (1 << size)) - 16'd1;
    return low << ofs;
  endfunction

  function automatic logic [L1D_DATA_W-1:0] line_data(mem_size_e size, logic [XLEN-1:0] data);
    logic [L1D_DATA_W-1:0] line;
    int nbytes;
    nbytes = 1 << size;
    for (int j = 0; j < L1D_BYTE_W; j++) begin
      line[j*8 +: 8] = data[(j % nbytes)*8 +: 8];
    end
    return line;
  endfunction

  // ========================================
  // Reference model
  // ========================================
  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      m_live    <= '0;
      m_addr_v  <= '0;
      m_data_v  <= '0;
      m_tail    <= '0;
      m_head    <= '0;
      m_count   <= 0;
      m_pending <= 0;
      acc_count <= 0;
    end else begin
      if (disp_valid) begin
        m_live[m_tail]   <= 1'b1;
        m_addr_v[m_tail] <= 1'b0;
        m_data_v[m_tail] <= 1'b0;
        m_tail           <= m_tail + 1'b1;
      end
      if (addr_upd.valid) begin
        m_addr_v[addr_upd.index] <= 1'b1;
        m_paddr[addr_upd.index]  <= addr_upd.paddr;
        m_size[addr_upd.index]   <= addr_upd.size;
      end
      if (data_upd.valid) begin
        m_data_v[data_upd.index] <= 1'b1;
        m_data[data_upd.index]   <= data_upd.data;
      end
      if (l1d_wr.valid && !wr_conflict) begin   // Write accepted by the cache
        m_live[m_head] <= 1'b0;
        m_head         <= m_head + 1'b1;
        acc_count      <= acc_count + 1;
      end
      m_pending <= m_pending + int'(commit) - int'(l1d_wr.valid && !wr_conflict);
      m_count   <= m_count + int'(disp_valid) - int'(l1d_wr.valid && !wr_conflict);
    end
  end

  always_comb begin
    exp_wr_paddr = m_paddr[m_head];
    exp_wr_be    = byte_mask(m_size[m_head], m_paddr[m_head][3:0]);
    exp_wr_data  = line_data(m_size[m_head], m_data[m_head]);
  end

  // Youngest overlapping store wins, walking from the head
  always_comb begin
    logic [STQ_IDX_W-1:0] k;
    logic [STQ_IDX_W-1:0] young;
    logic [15:0]          st_mask;
    logic [15:0]          ld_mask;
    logic                 found;
    logic                 no_addr;
    ld_mask    = byte_mask(fwd_req.size, {1'b0, fwd_req.paddr[2:0]});
    found      = 1'b0;
    no_addr    = 1'b0;
    young      = '0;
    exp_fwd_be = 8'h00;
    for (int i = 0; i < STQ_SIZE; i++) begin
      k       = m_head + STQ_IDX_W'(i);
      st_mask = byte_mask(m_size[k], {1'b0, m_paddr[k][2:0]});
      if (m_live[k] && !m_addr_v[k]) begin
        no_addr = 1'b1;
      end else if (m_live[k] && (m_paddr[k][PADDR_W-1:3] == fwd_req.paddr[PADDR_W-1:3]) &&
                   ((st_mask[7:0] & ld_mask[7:0]) != 8'h00)) begin
        found      = 1'b1;
        young      = k;
        exp_fwd_be = st_mask[7:0] & ld_mask[7:0];
      end
    end
    exp_fwd_valid = fwd_req.valid && found && m_data_v[young] && !no_addr;
    exp_hazard    = fwd_req.valid && (no_addr || (found && !m_data_v[young]));
    exp_fwd_data  = m_data[young];
  end

  // ========================================
  // Checks
  // ========================================
  a_idle: assert property (@(posedge clk) disable iff (!reset_n)
    chk_idle |-> (!l1d_wr.valid && !full && !fwd_resp.fwd_valid && !fwd_resp.hazard &&
                  (disp_index == '0)))
    else begin
      err_count++;
      $display("Mismatch %s: idle expected 0 actual wr %0b full %0b fv %0b hz %0b idx %0d",
               test_name, $sampled(l1d_wr.valid), $sampled(full),
               $sampled(fwd_resp.fwd_valid), $sampled(fwd_resp.hazard),
               $sampled(disp_index));
    end

  a_full: assert property (@(posedge clk) disable iff (!reset_n)
    full == (m_count == STQ_SIZE))
    else begin
      err_count++;
      $display("Mismatch %s: full expected %0b actual %0b", test_name,
               $sampled(m_count) == STQ_SIZE, $sampled(full));
    end

  a_disp_index: assert property (@(posedge clk) disable iff (!reset_n)
    disp_index == m_tail)
    else begin
      err_count++;
      $display("Mismatch %s: disp_index expected %0d actual %0d", test_name,
               $sampled(m_tail), $sampled(disp_index));
    end

  a_wr_pending: assert property (@(posedge clk) disable iff (!reset_n)
    l1d_wr.valid |-> (m_pending > 0))
    else begin
      err_count++;
      $display("L1D write issued in %s with no committed store waiting", test_name);
    end

  a_wr_match: assert property (@(posedge clk) disable iff (!reset_n)
    l1d_wr.valid |-> ((l1d_wr.paddr == exp_wr_paddr) && (l1d_wr.be == exp_wr_be) &&
                      (l1d_wr.data == exp_wr_data)))
    else begin
      err_count++;
      $display("Mismatch %s: write expected pa %h be %h data %h actual pa %h be %h data %h",
               test_name, $sampled(exp_wr_paddr), $sampled(exp_wr_be),
               $sampled(exp_wr_data), $sampled(l1d_wr.paddr), $sampled(l1d_wr.be),
               $sampled(l1d_wr.data));
    end

  a_wr_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (l1d_wr.valid && wr_conflict) |=> (l1d_wr.valid && $stable(l1d_wr)))
    else begin
      err_count++;
      $display("L1D write in %s was dropped or changed under a conflict", test_name);
    end

  a_fwd: assert property (@(posedge clk) disable iff (!reset_n)
    fwd_req.valid |-> ((fwd_resp.fwd_valid == exp_fwd_valid) &&
                       (fwd_resp.hazard == exp_hazard) &&
                       (!exp_fwd_valid || ((fwd_resp.fwd_be == exp_fwd_be) &&
                                           (fwd_resp.fwd_data == exp_fwd_data)))))
    else begin
      err_count++;
      $display("Mismatch %s: fwd expected v%0b hz%0b be %h d %h actual v%0b hz%0b be %h d %h",
               test_name, $sampled(exp_fwd_valid), $sampled(exp_hazard),
               $sampled(exp_fwd_be), $sampled(exp_fwd_data), $sampled(fwd_resp.fwd_valid),
               $sampled(fwd_resp.hazard), $sampled(fwd_resp.fwd_be),
               $sampled(fwd_resp.fwd_data));
    end

  // ========================================
  // Stimulus tasks
  // ========================================
  task automatic tick();
    @(posedge clk);
    #10;   // Drive after the edge
  endtask

  task automatic dispatch(output logic [STQ_IDX_W-1:0] idx);
    idx        = disp_index;
    disp_valid = 1'b1;
    tick();
    disp_valid = 1'b0;
  endtask

  task automatic send_addr(input logic [STQ_IDX_W-1:0] idx, input logic [PADDR_W-1:0] paddr,
                           input mem_size_e size);
    addr_upd.valid = 1'b1;
    addr_upd.index = idx;
    addr_upd.paddr = paddr;
    addr_upd.size  = size;
    tick();
    addr_upd.valid = 1'b0;
  endtask

  task automatic send_data(input logic [STQ_IDX_W-1:0] idx, input logic [XLEN-1:0] data);
    data_upd.valid = 1'b1;
    data_upd.index = idx;
    data_upd.data  = data;
    tick();
    data_upd.valid = 1'b0;
  endtask

  // Address and data land in random order
  task automatic make_store(input mem_size_e size, input logic [PADDR_W-1:0] paddr,
                            input logic [XLEN-1:0] data);
    logic [STQ_IDX_W-1:0] idx;
    logic [1:0]           order;
    dispatch(idx);
    order = 2'(rand_bits(2));
    if (order == 2'd0) begin
      data_upd.valid = 1'b1;
      data_upd.index = idx;
      data_upd.data  = data;
      send_addr(idx, paddr, size);
      data_upd.valid = 1'b0;
    end else if (order == 2'd1) begin
      send_addr(idx, paddr, size);
      send_data(idx, data);
    end else begin
      send_data(idx, data);
      send_addr(idx, paddr, size);
    end
  endtask

  task automatic make_rand_store();
    mem_size_e size;
    size = mem_size_e'(rand_bits(2));
    make_store(size, rand_paddr(size), rand_bits(XLEN));
  endtask

  task automatic commit_store();
    commit = 1'b1;
    tick();
    commit = 1'b0;
  endtask

  task automatic load_check(input logic [PADDR_W-1:0] paddr, input mem_size_e size);
    fwd_req.valid = 1'b1;
    fwd_req.paddr = paddr;
    fwd_req.size  = size;
    tick();
    fwd_req.valid = 1'b0;
  endtask

  task automatic wait_writes(input int target);
    int n;
    n = 0;
    while ((acc_count < target) && (n < TIMEOUT)) begin
      tick();
      n++;
    end
    if (acc_count < target) begin
      err_count++;
      $display("Timeout in %s: only %0d of %0d L1D writes accepted", test_name, acc_count,
               target);
    end
  endtask

  task automatic wait_write_valid();
    int n;
    n = 0;
    while (!l1d_wr.valid && (n < TIMEOUT)) begin
      tick();
      n++;
    end
    if (!l1d_wr.valid) begin
      err_count++;
      $display("Timeout in %s: no L1D write after commit", test_name);
    end
  endtask

  task automatic end_test(input int errs_before);
    test_count++;
    if (err_count != errs_before) begin
      fail_count++;
    end
    $display("Test %s: %s, %0d errors", test_name,
             (err_count == errs_before) ? "ok" : "failed", err_count - errs_before);
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    logic [STQ_IDX_W-1:0] idx;
    logic [PADDR_W-1:0]   pa;
    int                   errs;
    int                   base;
    int                   hold;
    lfsr        = 32'h5d89;
    err_count   = 0;
    test_count  = 0;
    fail_count  = 0;
    chk_idle    = 1'b0;
    reset_n     = 1'b0;
    disp_valid  = 1'b0;
    addr_upd    = '0;
    data_upd    = '0;
    commit      = 1'b0;
    fwd_req     = '0;
    wr_conflict = 1'b0;
    test_name   = "reset";
    repeat (16) @(posedge clk);
    #10;
    reset_n = 1'b1;
    tick();

    errs     = err_count;
    chk_idle = 1'b1;
    load_check(rand_paddr(SIZE_D), SIZE_D);
    chk_idle = 1'b0;
    end_test(errs);

    test_name = "fill";
    errs      = err_count;
    base      = acc_count;
    for (int i = 0; i < STQ_SIZE; i++) begin
      make_rand_store();
    end
    tick();
    commit_store();
    wait_writes(base + 1);
    tick();
    for (int i = 1; i < STQ_SIZE; i++) begin
      commit_store();
    end
    wait_writes(base + STQ_SIZE);
    end_test(errs);

    test_name = "sizes";
    errs      = err_count;
    base      = acc_count;
    for (int s = 0; s < 4; s++) begin
      make_store(mem_size_e'(s), rand_paddr(mem_size_e'(s)), rand_bits(XLEN));
    end
    for (int s = 0; s < 4; s++) begin
      commit_store();
    end
    wait_writes(base + 4);
    end_test(errs);

    test_name = "forward";
    errs      = err_count;
    base      = acc_count;
    pa        = rand_paddr(SIZE_D);
    make_store(SIZE_D, pa, rand_bits(XLEN));
    make_store(SIZE_W, pa + 32'd4, rand_bits(XLEN));
    load_check(pa + 32'd4, SIZE_H);      // Covered by the younger word
    load_check(pa, SIZE_B);              // Only the older dword overlaps
    load_check(pa ^ 32'h40, SIZE_D);     // Other dword
    commit_store();
    commit_store();
    wait_writes(base + 2);
    end_test(errs);

    test_name = "hazard";
    errs      = err_count;
    base      = acc_count;
    dispatch(idx);
    load_check(rand_paddr(SIZE_D), SIZE_D);
    pa = rand_paddr(SIZE_W);
    send_addr(idx, pa, SIZE_W);
    load_check(pa, SIZE_B);
    send_data(idx, rand_bits(XLEN));
    load_check(pa, SIZE_B);
    commit_store();
    wait_writes(base + 1);
    end_test(errs);

    test_name = "conflict";
    errs      = err_count;
    for (int r = 0; r < 3; r++) begin
      base = acc_count;
      make_rand_store();
      wr_conflict = 1'b1;
      commit_store();
      wait_write_valid();
      hold = 2 + int'(rand_bits(3));
      repeat (hold) tick();
      wr_conflict = 1'b0;
      wait_writes(base + 1);
      repeat (3) tick();
      assert (acc_count == base + 1)
        else begin
          err_count++;
          $display("Mismatch %s: accepted writes expected %0d actual %0d", test_name,
                   base + 1, acc_count);
        end
    end
    end_test(errs);

    $display("Tests run %0d, tests failed %0d, errors %0d", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== src/stq_top.sv ====
module stq_top
  import stq_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_disp_valid,
  input  addr_upd_t            i_addr_upd,
  input  data_upd_t            i_data_upd,
  input  logic                 i_commit,
  input  fwd_req_t             i_fwd_req,
  input  logic                 i_l1d_wr_conflict,
  output logic [STQ_IDX_W-1:0] o_disp_index,
  output logic                 o_full,
  output fwd_resp_t            o_fwd_resp,
  output l1d_wr_t              o_l1d_wr
);

  logic [STQ_IDX_W-1:0] r_tail;
  logic [STQ_IDX_W-1:0] r_cmt;
  logic [STQ_IDX_W-1:0] r_head;
  logic [STQ_IDX_W:0]   r_count;
  logic                 w_finish;
  logic [STQ_SIZE-1:0]  w_alloc;
  logic [STQ_SIZE-1:0]  w_commit;
  logic [STQ_SIZE-1:0]  w_free;
  stq_entry_t           w_entries [STQ_SIZE];

  assign o_disp_index = r_tail;
  assign o_full       = (r_count == (STQ_IDX_W + 1)'(STQ_SIZE));

  // ========================================
  // Ring pointers and occupancy
  // ========================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail  <= '0;
      r_cmt   <= '0;
      r_head  <= '0;
      r_count <= '0;
    end else begin
      if (i_disp_valid) begin
        r_tail <= r_tail + 1'b1;
      end
      if (i_commit) begin
        r_cmt <= r_cmt + 1'b1;   // Oldest uncommitted store
      end
      if (w_finish) begin
        r_head <= r_head + 1'b1;
      end
      case ({i_disp_valid, w_finish})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // ========================================
  // Entry array
  // ========================================
  for (genvar g = 0; g < STQ_SIZE; g++) begin : g_entry
    assign w_alloc[g]  = i_disp_valid && (r_tail == STQ_IDX_W'(g));
    assign w_commit[g] = i_commit && (r_cmt == STQ_IDX_W'(g));
    assign w_free[g]   = w_finish && (r_head == STQ_IDX_W'(g));

    stq_entry #(
      .ENTRY_IDX (g)
    ) u_entry (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_alloc    (w_alloc[g]),
      .i_addr_upd (i_addr_upd),
      .i_data_upd (i_data_upd),
      .i_commit   (w_commit[g]),
      .i_free     (w_free[g]),
      .o_entry    (w_entries[g])
    );
  end

  // Load check against every live store
  stq_fwd_check u_fwd_check (
    .i_entries  (w_entries),
    .i_head_idx (r_head),
    .i_req      (i_fwd_req),
    .o_resp     (o_fwd_resp)
  );

  stq_store_drain u_store_drain (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_head            (w_entries[r_head]),
    .i_l1d_wr_conflict (i_l1d_wr_conflict),
    .o_l1d_wr          (o_l1d_wr),
    .o_finish          (w_finish)
  );

  // Dispatch stalls on a full queue
  a_no_disp_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> !o_full)
    else $error("Dispatch into a full store queue");

endmodule

// ==== src/stq_store_drain.sv ====
module stq_store_drain
  import stq_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  stq_entry_t i_head,
  input  logic       i_l1d_wr_conflict,
  output l1d_wr_t    o_l1d_wr,
  output logic       o_finish
);

  logic               r_busy;
  logic [PADDR_W-1:0] r_paddr;
  mem_size_e          r_size;
  logic [XLEN-1:0]    r_data;
  logic               w_capture;

  // Head is taken only when nothing is in flight
  assign w_capture = !r_busy && (i_head.state == STQ_COMMIT);
  assign o_finish  = r_busy && !i_l1d_wr_conflict;   // Accepted write

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy <= 1'b0;
    end else if (w_capture) begin
      r_busy <= 1'b1;
    end else if (o_finish) begin
      r_busy <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_capture) begin
      r_paddr <= i_head.paddr;
      r_size  <= i_head.size;
      r_data  <= i_head.data;
    end
  end

  // ========================================
  // Line-wide L1D write
  // ========================================
  always_comb begin
    o_l1d_wr.valid = r_busy;
    o_l1d_wr.paddr = r_paddr;
    o_l1d_wr.data  = size_replicate(r_size, r_data);
    o_l1d_wr.be    = {{(L1D_BYTE_W - 8){1'b0}}, size_mask(r_size, 3'b000)}
                     << r_paddr[L1D_OFS_W-1:0];   // Byte position within the line
  end

  // A refused write is repeated as is, and the head entry behind it stays put
  a_hold_on_conflict: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_l1d_wr.valid && i_l1d_wr_conflict) |=>
      (o_l1d_wr.valid && $stable(o_l1d_wr) && $stable(i_head)))
    else $error("L1D write or its head entry changed while held by a conflict");

endmodule

// ==== src/stq_fwd_check.sv ====
module stq_fwd_check
  import stq_pkg::*;
(
  input  stq_entry_t           i_entries [STQ_SIZE],
  input  logic [STQ_IDX_W-1:0] i_head_idx,
  input  fwd_req_t             i_req,
  output fwd_resp_t            o_resp
);

  logic [7:0]           w_ld_mask;
  logic [7:0]           w_st_mask [STQ_SIZE];
  logic [STQ_SIZE-1:0]  w_live;
  logic [STQ_SIZE-1:0]  w_no_addr;
  logic [STQ_SIZE-1:0]  w_overlap;
  logic                 w_addr_missing;
  logic                 w_young_found;
  logic [STQ_IDX_W-1:0] w_young_idx;

  assign w_ld_mask = size_mask(i_req.size, i_req.paddr[2:0]);

  // ========================================
  // Per-entry overlap
  // ========================================
  for (genvar g = 0; g < STQ_SIZE; g++) begin : g_entry
    assign w_st_mask[g] = size_mask(i_entries[g].size, i_entries[g].paddr[2:0]);
    assign w_live[g]    = (i_entries[g].state != STQ_EMPTY);
    assign w_no_addr[g] = w_live[g] && !i_entries[g].paddr_valid;
    assign w_overlap[g] = w_live[g] && i_entries[g].paddr_valid &&
                          (i_entries[g].paddr[PADDR_W-1:3] == i_req.paddr[PADDR_W-1:3]) &&
                          (|(w_st_mask[g] & w_ld_mask));
  end

  assign w_addr_missing = |w_no_addr;   // Unknown address may alias anything

  // Oldest to youngest, the last hit wins
  always_comb begin
    logic [STQ_IDX_W-1:0] idx;
    w_young_found = 1'b0;
    w_young_idx   = '0;
    for (int i = 0; i < STQ_SIZE; i++) begin
      idx = i_head_idx + STQ_IDX_W'(i);
      if (w_overlap[idx]) begin
        w_young_found = 1'b1;
        w_young_idx   = idx;
      end
    end
  end

  // ========================================
  // Response
  // ========================================
  always_comb begin
    logic young_has_data;
    logic fwd_ok;
    young_has_data = i_entries[w_young_idx].data_valid;
    fwd_ok = i_req.valid && w_young_found && young_has_data && !w_addr_missing;

    o_resp.fwd_valid = fwd_ok;
    o_resp.hazard    = i_req.valid &&
                       (w_addr_missing || (w_young_found && !young_has_data));
    o_resp.fwd_be    = fwd_ok ? (w_st_mask[w_young_idx] & w_ld_mask) : 8'h00;
    o_resp.fwd_data  = i_entries[w_young_idx].data;
  end

endmodule

// ==== src/stq_entry.sv ====
module stq_entry
  import stq_pkg::*;
#(
  parameter int unsigned ENTRY_IDX = 0
) (
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_alloc,
  input  addr_upd_t  i_addr_upd,
  input  data_upd_t  i_data_upd,
  input  logic       i_commit,
  input  logic       i_free,
  output stq_entry_t o_entry
);

  stq_state_e         r_state;
  stq_state_e         w_state_next;
  logic               r_paddr_valid;
  logic               r_data_valid;
  logic [PADDR_W-1:0] r_paddr;
  mem_size_e          r_size;
  logic [XLEN-1:0]    r_data;
  logic               w_addr_hit;
  logic               w_data_hit;

  assign w_addr_hit = i_addr_upd.valid && (i_addr_upd.index == STQ_IDX_W'(ENTRY_IDX));
  assign w_data_hit = i_data_upd.valid && (i_data_upd.index == STQ_IDX_W'(ENTRY_IDX));

  // ========================================
  // Entry FSM
  // ========================================
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      STQ_EMPTY: begin
        if (i_alloc) begin
          w_state_next = STQ_WAIT_ADDR_DATA;
        end
      end
      STQ_WAIT_ADDR_DATA: begin
        if (w_addr_hit && w_data_hit) begin
          w_state_next = STQ_READY;     // Both in one cycle
        end else if (w_addr_hit) begin
          w_state_next = STQ_WAIT_DATA;
        end else if (w_data_hit) begin
          w_state_next = STQ_WAIT_ADDR;
        end
      end
      STQ_WAIT_ADDR: begin
        if (w_addr_hit) begin
          w_state_next = STQ_READY;
        end
      end
      STQ_WAIT_DATA: begin
        if (w_data_hit) begin
          w_state_next = STQ_READY;
        end
      end
      STQ_READY: begin
        if (i_commit) begin
          w_state_next = STQ_COMMIT;
        end
      end
      STQ_COMMIT: begin
        if (i_free) begin
          w_state_next = STQ_EMPTY;     // Written to L1D
        end
      end
      default: w_state_next = STQ_EMPTY;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state       <= STQ_EMPTY;
      r_paddr_valid <= 1'b0;
      r_data_valid  <= 1'b0;
    end else begin
      r_state <= w_state_next;
      if (i_alloc || i_free) begin
        r_paddr_valid <= 1'b0;
        r_data_valid  <= 1'b0;
      end else begin
        if (w_addr_hit) begin
          r_paddr_valid <= 1'b1;
        end
        if (w_data_hit) begin
          r_data_valid <= 1'b1;
        end
      end
    end
  end

  // Captured fields
  always_ff @(posedge i_clk) begin
    if (w_addr_hit) begin
      r_paddr <= i_addr_upd.paddr;
      r_size  <= i_addr_upd.size;
    end
    if (w_data_hit) begin
      r_data <= i_data_upd.data;
    end
  end

  always_comb begin
    o_entry.state       = r_state;
    o_entry.paddr_valid = r_paddr_valid;
    o_entry.data_valid  = r_data_valid;
    o_entry.paddr       = r_paddr;
    o_entry.size        = r_size;
    o_entry.data        = r_data;
  end

  // The pipe only updates entries that dispatch has allocated
  a_no_update_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_addr_hit || w_data_hit) |-> (r_state != STQ_EMPTY))
    else $error("Update to empty store queue entry %0d", ENTRY_IDX);

  a_commit_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit |-> (r_state == STQ_READY))
    else $error("Commit of store queue entry %0d before it is ready", ENTRY_IDX);

endmodule

// ==== src/stq_pkg.sv ====
package stq_pkg;

  // ========================================
  // Sizes
  // ========================================
  localparam int STQ_SIZE   = 8;
  localparam int STQ_IDX_W  = 3;
  localparam int PADDR_W    = 32;
  localparam int XLEN       = 64;
  localparam int L1D_DATA_W = 128;
  localparam int L1D_BYTE_W = 16;   // Bytes per cache write
  localparam int L1D_OFS_W  = 4;    // Byte offset within a cache write

  // ========================================
  // Types
  // ========================================
  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W,
    SIZE_D
  } mem_size_e;

  typedef enum logic [2:0] {
    STQ_EMPTY,
    STQ_WAIT_ADDR_DATA,
    STQ_WAIT_ADDR,
    STQ_WAIT_DATA,
    STQ_READY,
    STQ_COMMIT
  } stq_state_e;

  typedef struct packed {
    stq_state_e         state;
    logic               paddr_valid;
    logic               data_valid;
    logic [PADDR_W-1:0] paddr;
    mem_size_e          size;
    logic [XLEN-1:0]    data;
  } stq_entry_t;

  // Address update from the pipe
  typedef struct packed {
    logic                 valid;
    logic [STQ_IDX_W-1:0] index;
    logic [PADDR_W-1:0]   paddr;
    mem_size_e            size;
  } addr_upd_t;

  // Store data update from the pipe
  typedef struct packed {
    logic                 valid;
    logic [STQ_IDX_W-1:0] index;
    logic [XLEN-1:0]      data;
  } data_upd_t;

  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
    mem_size_e          size;
  } fwd_req_t;

  typedef struct packed {
    logic            fwd_valid;
    logic            hazard;
    logic [7:0]      fwd_be;
    logic [XLEN-1:0] fwd_data;
  } fwd_resp_t;

  typedef struct packed {
    logic                  valid;
    logic [PADDR_W-1:0]    paddr;
    logic [L1D_DATA_W-1:0] data;
    logic [L1D_BYTE_W-1:0] be;
  } l1d_wr_t;

  // ========================================
  // Byte mask helpers
  // ========================================

  // Dword byte mask of an access at byte offset ofs
  function automatic logic [7:0] size_mask(mem_size_e size, logic [2:0] ofs);
    logic [7:0] base;
    case (size)
      SIZE_B:  base = 8'h01;
      SIZE_H:  base = 8'h03;
      SIZE_W:  base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << ofs;
  endfunction

  // Low size bytes repeated over the whole cache write
  function automatic logic [L1D_DATA_W-1:0] size_replicate(mem_size_e size,
                                                         logic [XLEN-1:0] data);
    case (size)
      SIZE_B:  return {(L1D_DATA_W / 8){data[7:0]}};
      SIZE_H:  return {(L1D_DATA_W / 16){data[15:0]}};
      SIZE_W:  return {(L1D_DATA_W / 32){data[31:0]}};
      default: return {(L1D_DATA_W / 64){data[63:0]}};
    endcase
  endfunction

endpackage
